// File: source/cpuTypesPkg.sv
// ---------------------------------------------------------------------------
// shared types for the pipelined core
// MIPS-style encodings; only the opcodes and functs listed here are decoded
// anything else decodes as a no-op with no register or memory write
// ---------------------------------------------------------------------------
package cpuTypesPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regBits_t;

  // primary opcodes
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    BEQ   = 6'h04,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // R-type function codes
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,  // signed compare
    ALU_SLL
  } aluOp_t;

  typedef struct packed {
    opcode_t  opcode;
    regBits_t rs;
    regBits_t rt;
    regBits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } rInstr_t;

  typedef struct packed {
    opcode_t  opcode;
    regBits_t rs;
    regBits_t rt;
    logic [15:0] imm;
  } iInstr_t;

  // one instruction word, two field layouts
  typedef union packed {
    rInstr_t r;
    iInstr_t i;
  } instr_t;

  // all ones ends the program
  parameter word_t haltWord = 32'hffff_ffff;

endpackage

// File: source/fetchStage.sv
// ---------------------------------------------------------------------------
// program counter and IF/ID register
// everything moves only on advance; a taken branch wins over a hazard stall
// a flushed IF/ID holds the all-zero word, which decodes as a no-op
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module fetchStage import cpuTypesPkg::*; #(
  parameter word_t pcInit = '0
) (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   advance,
  input  logic   hazardStall,
  input  logic   branchTaken,
  input  word_t  branchTarget,
  input  logic   halt,
  input  word_t  imemload,
  output logic   imemREN,
  output word_t  imemaddr,
  output instr_t ifInstr,
  output word_t  ifPc
);

  word_t pc;
  word_t pcNext;

  assign imemaddr = pc;
  assign imemREN  = ~halt;  // no more fetches once halted

  always_comb begin
    if (branchTaken)
      pcNext = branchTarget;
    else if (hazardStall)
      pcNext = pc;
    else
      pcNext = pc + 32'd4;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= pcInit;
    end else if (advance) begin
      pc <= pcNext;
    end
  end

  // IF/ID instruction, cleared to a no-op on flush
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ifInstr <= '0;
    end else if (advance) begin
      if (branchTaken)
        ifInstr <= '0;  // shadow of a taken branch
      else if (!hazardStall)
        ifInstr <= imemload;
    end
  end

  // IF/ID pc, payload only
  always_ff @(posedge CLK) begin
    if (advance && !hazardStall && !branchTaken) begin
      ifPc <= pc;
    end
  end

endmodule

// File: source/registerFile.sv
// ---------------------------------------------------------------------------
// 32 x 32 register file, two read ports and one write port
// register zero always reads as zero and ignores writes
// a read of the register being written returns the new value
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module registerFile import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  regBits_t rsel1,
  input  regBits_t rsel2,
  input  logic     wen,
  input  regBits_t wsel,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-before-read bypass
  always_comb begin
    if (rsel1 == '0)
      rdat1 = '0;
    else if (wen && wsel == rsel1)
      rdat1 = wdat;
    else
      rdat1 = regs[rsel1];
  end

  always_comb begin
    if (rsel2 == '0)
      rdat2 = '0;
    else if (wen && wsel == rsel2)
      rdat2 = wdat;
    else
      rdat2 = regs[rsel2];
  end

endmodule

// File: source/decodeUnit.sv
// ---------------------------------------------------------------------------
// control decode, RAW hazard detection and the ID/EX register
// no forwarding: a reader waits until its producer reaches writeback
// write enables are only ever set with a nonzero destination
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module decodeUnit import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     advance,
  input  instr_t   ifInstr,
  input  word_t    ifPc,
  input  logic     branchTaken,
  input  regBits_t exDest,
  input  logic     exWen,
  input  regBits_t memDest,
  input  logic     memWen,
  input  logic     wbWen,
  input  regBits_t wbSel,
  input  word_t    wbData,
  output logic     hazardStall,
  output instr_t   idInstr,
  output word_t    idPc,
  output word_t    idRdat1,
  output word_t    idRdat2,
  output regBits_t idDest,
  output aluOp_t   idAluOp,
  output logic     idAluSrc,
  output logic     idZeroExt,
  output logic     idWen,
  output logic     idMemRead,
  output logic     idMemWrite,
  output logic     idBranch,
  output logic     idLui
);

  opcode_t  opcode;
  regBits_t rs, rt, dest;
  word_t    rdat1, rdat2;
  aluOp_t   aluOp;
  logic aluSrc, zeroExt, regDst, wen, memRead, memWrite, branch, lui;
  logic usesRs, usesRt, bubble;

  assign opcode = ifInstr.r.opcode;
  assign rs     = ifInstr.r.rs;
  assign rt     = ifInstr.r.rt;

  always_comb begin
    {aluSrc, zeroExt, regDst, wen, memRead, memWrite, branch, lui} = '0;
    aluOp = ALU_ADD;
    case (opcode)
      RTYPE: begin
        regDst = 1'b1;
        wen    = 1'b1;
        case (ifInstr.r.funct)
          ADDU:    aluOp = ALU_ADD;
          SUBU:    aluOp = ALU_SUB;
          AND:     aluOp = ALU_AND;
          OR:      aluOp = ALU_OR;
          SLT:     aluOp = ALU_SLT;
          SLL:     aluOp = ALU_SLL;
          default: wen   = 1'b0;  // unknown funct, no write
        endcase
      end
      ADDIU: {aluSrc, wen} = 2'b11;
      ORI: begin
        {aluSrc, zeroExt, wen} = 3'b111;
        aluOp = ALU_OR;
      end
      LUI:   {lui, wen} = 2'b11;
      LW:    {aluSrc, memRead, wen} = 3'b111;
      SW:    {aluSrc, memWrite} = 2'b11;
      BEQ:   branch = 1'b1;
      default: ;  // halt and unknown opcodes
    endcase
  end

  assign dest = regDst ? ifInstr.r.rd : ifInstr.i.rt;

  // source usage, so rt as a destination does not stall
  assign usesRs = (opcode != LUI) && !(opcode == RTYPE && ifInstr.r.funct == SLL);
  assign usesRt = (opcode == RTYPE) || (opcode == SW) || (opcode == BEQ);

  function automatic logic dependsOn(regBits_t d, logic w, regBits_t s1, regBits_t s2,
                                     logic u1, logic u2);
    logic hit;
    hit = w && (d != '0) && ((u1 && d == s1) || (u2 && d == s2));
    return hit;
  endfunction

  // MEM/WB only matters when its write is not committed this cycle
  assign hazardStall = dependsOn(idDest, idWen, rs, rt, usesRs, usesRt)
                     | dependsOn(exDest, exWen, rs, rt, usesRs, usesRt)
                     | dependsOn(memDest, memWen & ~wbWen, rs, rt, usesRs, usesRt);

  assign bubble = branchTaken | hazardStall;

  registerFile rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .rsel1 (rs),
    .rsel2 (rt),
    .wen   (wbWen),
    .wsel  (wbSel),
    .wdat  (wbData),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // ID/EX control
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      idInstr <= '0;
      idDest  <= '0;
      idAluOp <= ALU_ADD;
      {idAluSrc, idZeroExt, idWen, idMemRead, idMemWrite, idBranch, idLui} <= '0;
    end else if (advance) begin
      idInstr    <= bubble ? '0 : ifInstr;
      idDest     <= dest;
      idAluOp    <= aluOp;
      idAluSrc   <= aluSrc;
      idZeroExt  <= zeroExt;
      idWen      <= ~bubble & wen & (dest != '0);
      idMemRead  <= ~bubble & memRead;
      idMemWrite <= ~bubble & memWrite;
      idBranch   <= ~bubble & branch;
      idLui      <= ~bubble & lui;
    end
  end

  // ID/EX payload
  always_ff @(posedge CLK) begin
    if (advance) begin
      idPc    <= ifPc;
      idRdat1 <= rdat1;
      idRdat2 <= rdat2;
    end
  end

endmodule

// File: source/executeUnit.sv
// ---------------------------------------------------------------------------
// ALU, BEQ resolution and the EX/MEM register
// branchTaken is combinational from ID/EX and acts on the next advance
// SLL shifts rt by shamt; LUI bypasses the ALU
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module executeUnit import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     advance,
  input  instr_t   idInstr,
  input  word_t    idPc,
  input  word_t    idRdat1,
  input  word_t    idRdat2,
  input  regBits_t idDest,
  input  aluOp_t   idAluOp,
  input  logic     idAluSrc,
  input  logic     idZeroExt,
  input  logic     idWen,
  input  logic     idMemRead,
  input  logic     idMemWrite,
  input  logic     idBranch,
  input  logic     idLui,
  output logic     branchTaken,
  output word_t    branchTarget,
  output regBits_t exDest,
  output logic     exWen,
  output word_t    exAluOut,
  output word_t    exStore,
  output logic     exMemRead,
  output logic     exMemWrite,
  output instr_t   exInstr
);

  word_t immExt, portA, portB, aluOut, result;
  logic [15:0] imm;

  assign imm    = idInstr.i.imm;
  assign immExt = idZeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};

  // operand select
  always_comb begin
    portA = idRdat1;
    portB = idRdat2;
    if (idAluOp == ALU_SLL) begin
      portA = idRdat2;
      portB = {27'b0, idInstr.r.shamt};
    end else if (idAluSrc) begin
      portB = immExt;
    end
  end

  always_comb begin
    case (idAluOp)
      ALU_SUB: aluOut = portA - portB;
      ALU_AND: aluOut = portA & portB;
      ALU_OR:  aluOut = portA | portB;
      ALU_SLT: aluOut = {31'b0, $signed(portA) < $signed(portB)};
      ALU_SLL: aluOut = portA << portB[4:0];
      default: aluOut = portA + portB;
    endcase
  end

  assign result = idLui ? {imm, 16'b0} : aluOut;

  // BEQ, target relative to the delay-free next pc
  assign branchTaken  = idBranch && (idRdat1 == idRdat2);
  assign branchTarget = idPc + 32'd4 + {immExt[29:0], 2'b00};

  // EX/MEM control
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exDest     <= '0;
      exWen      <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exInstr    <= '0;
    end else if (advance) begin
      exDest     <= idDest;
      exWen      <= idWen;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
      exInstr    <= idInstr;
    end
  end

  // EX/MEM payload
  always_ff @(posedge CLK) begin
    if (advance) begin
      exAluOut <= result;
      exStore  <= idRdat2;
    end
  end

endmodule

// File: source/memWriteback.sv
// ---------------------------------------------------------------------------
// data memory request, pipeline advance, MEM/WB register and halt flag
// a data access that completes while ihit is low is held in memDone so the
// request is not issued twice; halt is sticky until reset
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module memWriteback import cpuTypesPkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     ihit,
  input  logic     dhit,
  input  word_t    dmemload,
  input  regBits_t exDest,
  input  logic     exWen,
  input  word_t    exAluOut,
  input  word_t    exStore,
  input  logic     exMemRead,
  input  logic     exMemWrite,
  input  instr_t   exInstr,
  output logic     advance,
  output regBits_t memDest,
  output logic     memWen,
  output logic     dmemREN,
  output logic     dmemWEN,
  output word_t    dmemaddr,
  output word_t    dmemstore,
  output logic     wbWen,
  output regBits_t wbSel,
  output word_t    wbData,
  output logic     halt
);

  logic  squash, memReq, memDone, wbHalt;
  word_t loadBuf, loadValue;

  // anything behind the halt word never touches memory
  assign squash = halt | wbHalt;
  assign memReq = (exMemRead | exMemWrite) & ~squash;

  assign dmemREN   = exMemRead & ~squash & ~memDone;
  assign dmemWEN   = exMemWrite & ~squash & ~memDone;
  assign dmemaddr  = exAluOut;
  assign dmemstore = exStore;

  assign advance = ihit & (~memReq | dhit | memDone);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memDone <= 1'b0;
    end else if (advance) begin
      memDone <= 1'b0;
    end else if (memReq && dhit) begin
      memDone <= 1'b1;  // finished, waiting on fetch
    end
  end

  always_ff @(posedge CLK) begin
    if (dhit && !memDone) begin
      loadBuf <= dmemload;
    end
  end

  assign loadValue = memDone ? loadBuf : dmemload;

  // MEM/WB control
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      memDest <= '0;
      memWen  <= 1'b0;
      wbHalt  <= 1'b0;
    end else if (advance) begin
      memDest <= exDest;
      memWen  <= exWen;
      wbHalt  <= (exInstr == haltWord);
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      wbData <= exMemRead ? loadValue : exAluOut;
    end
  end

  // commit once, on the edge that moves MEM/WB on
  assign wbWen = memWen & advance;
  assign wbSel = memDest;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (wbHalt) begin
      halt <= 1'b1;
    end
  end

endmodule

// File: source/pipelineCpu.sv
// ---------------------------------------------------------------------------
// five-stage core top level
// separate instruction and data ports, each completing on its hit signal
// pcInit sets the first fetch address after reset
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module pipelineCpu import cpuTypesPkg::*; #(
  parameter word_t pcInit = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  word_t imemload,
  output logic  imemREN,
  output word_t imemaddr,
  input  logic  dhit,
  input  word_t dmemload,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  halt
);

  logic     advance, hazardStall, branchTaken;
  word_t    branchTarget, ifPc, idPc, idRdat1, idRdat2;
  instr_t   ifInstr, idInstr, exInstr;
  regBits_t idDest, exDest, memDest, wbSel;
  aluOp_t   idAluOp;
  logic     idAluSrc, idZeroExt, idWen, idMemRead, idMemWrite, idBranch, idLui;
  logic     exWen, exMemRead, exMemWrite, memWen, wbWen;
  word_t    exAluOut, exStore, wbData;

  fetchStage #(.pcInit(pcInit)) fetch (
    .CLK, .nRST, .advance, .hazardStall, .branchTaken, .branchTarget, .halt,
    .imemload, .imemREN, .imemaddr, .ifInstr, .ifPc
  );

  decodeUnit decode (
    .CLK, .nRST, .advance, .ifInstr, .ifPc, .branchTaken,
    .exDest, .exWen, .memDest, .memWen, .wbWen, .wbSel, .wbData,
    .hazardStall, .idInstr, .idPc, .idRdat1, .idRdat2, .idDest, .idAluOp,
    .idAluSrc, .idZeroExt, .idWen, .idMemRead, .idMemWrite, .idBranch, .idLui
  );

  executeUnit execute (
    .CLK, .nRST, .advance, .idInstr, .idPc, .idRdat1, .idRdat2, .idDest,
    .idAluOp, .idAluSrc, .idZeroExt, .idWen, .idMemRead, .idMemWrite,
    .idBranch, .idLui, .branchTaken, .branchTarget, .exDest, .exWen,
    .exAluOut, .exStore, .exMemRead, .exMemWrite, .exInstr
  );

  memWriteback memWb (
    .CLK, .nRST, .ihit, .dhit, .dmemload, .exDest, .exWen, .exAluOut,
    .exStore, .exMemRead, .exMemWrite, .exInstr, .advance, .memDest, .memWen,
    .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .wbWen, .wbSel, .wbData, .halt
  );

endmodule

// File: tb/cpuRefModel.svh
// ---------------------------------------------------------------------------
// program builders and an instruction-level model of the core
// programs start at word 0 of the instruction window; missing words are halt
// the model stops at the halt word or after 1000 instructions
// ---------------------------------------------------------------------------
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

word_t prog [$];
word_t expAddr [$];
word_t expData [$];
word_t refMem [word_t];
int    refCount;

function automatic word_t rOp(funct_t f, regBits_t rd, regBits_t rs, regBits_t rt,
                              logic [4:0] sh);
  instr_t w;
  w.r.opcode = RTYPE;
  w.r.rs     = rs;
  w.r.rt     = rt;
  w.r.rd     = rd;
  w.r.shamt  = sh;
  w.r.funct  = f;
  return w;
endfunction

function automatic word_t iOp(opcode_t op, regBits_t rt, regBits_t rs, logic [15:0] imm);
  instr_t w;
  w.i.opcode = op;
  w.i.rs     = rs;
  w.i.rt     = rt;
  w.i.imm    = imm;
  return w;
endfunction

// initial data memory contents, different for every address
function automatic word_t memFill(word_t addr);
  return {addr[15:0] ^ 16'h5a5a, addr[31:16] ^ 16'hc3e1} + (addr >> 3);
endfunction

function automatic void refRun();
  word_t  regs [32];
  word_t  a, b, addr, immS;
  instr_t w;
  int     pc;
  int     steps;
  for (int k = 0; k < 32; k++) regs[k] = '0;
  refMem.delete();
  expAddr.delete();
  expData.delete();
  pc = 0;
  steps = 0;
  while (steps < 1000) begin
    w = (pc < prog.size()) ? prog[pc] : haltWord;
    steps++;
    if (w == haltWord) break;
    a    = regs[w.r.rs];
    b    = regs[w.r.rt];
    immS = {{16{w.i.imm[15]}}, w.i.imm};
    addr = a + immS;
    pc++;
    case (w.r.opcode)
      RTYPE: begin
        case (w.r.funct)
          ADDU: regs[w.r.rd] = a + b;
          SUBU: regs[w.r.rd] = a - b;
          AND:  regs[w.r.rd] = a & b;
          OR:   regs[w.r.rd] = a | b;
          SLT:  regs[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          SLL:  regs[w.r.rd] = b << w.r.shamt;
          default: ;
        endcase
      end
      ADDIU: regs[w.i.rt] = a + immS;
      ORI:   regs[w.i.rt] = a | {16'b0, w.i.imm};
      LUI:   regs[w.i.rt] = {w.i.imm, 16'b0};
      LW:    regs[w.i.rt] = refMem.exists(addr) ? refMem[addr] : memFill(addr);
      SW: begin
        refMem[addr] = b;
        expAddr.push_back(addr);
        expData.push_back(b);
      end
      BEQ: if (a == b) pc = pc + int'($signed(w.i.imm));
      default: ;
    endcase
    regs[0] = '0;
  end
  refCount = steps;
endfunction

// random ALU ops, each result stored to its own address
function automatic void buildRandomMix(int n);
  regBits_t d, s, t;
  logic [15:0] imm;
  word_t op;
  prog.delete();
  for (int k = 0; k < n; k++) begin
    d   = 5'($urandom_range(7, 1));
    s   = 5'($urandom_range(7, 0));
    t   = 5'($urandom_range(7, 0));
    imm = 16'($urandom);
    case ($urandom_range(8, 0))
      0:       op = rOp(ADDU, d, s, t, 5'd0);
      1:       op = rOp(SUBU, d, s, t, 5'd0);
      2:       op = rOp(AND, d, s, t, 5'd0);
      3:       op = rOp(OR, d, s, t, 5'd0);
      4:       op = rOp(SLT, d, s, t, 5'd0);
      5:       op = rOp(SLL, d, 5'd0, t, imm[4:0]);
      6:       op = iOp(ADDIU, d, s, imm);
      7:       op = iOp(ORI, d, s, imm);
      default: op = iOp(LUI, d, 5'd0, imm);
    endcase
    prog.push_back(op);
    prog.push_back(iOp(SW, d, 5'd0, 16'(16'h400 + 4 * k)));
  end
  prog.push_back(haltWord);
  // stores behind the halt word must never reach memory
  prog.push_back(iOp(SW, 5'd1, 5'd0, 16'h7f0));
  prog.push_back(iOp(SW, 5'd2, 5'd0, 16'h7f4));
endfunction

`endif

// File: tb/tbPipelineCpu.sv
// ---------------------------------------------------------------------------
// testbench for the pipelined core
// each program runs once with zero waits and once with 0..3 random waits
// stores are checked in order against the instruction-level model
// ---------------------------------------------------------------------------
`timescale 1ns/10ps

module tbPipelineCpu import cpuTypesPkg::*; ();

  localparam word_t pcInit = 32'h0000_0100;

  logic  CLK, nRST, ihit, dhit, imemREN, dmemREN, dmemWEN, halt;
  word_t imemload, imemaddr, dmemload, dmemaddr, dmemstore;

  word_t imem [256];
  word_t dataMem [word_t];
  int    iCnt, dCnt, iNext, dNext;
  bit    randomMode, running;
  int    storeIdx, cycles, cycleLimit;

  `include "cpuRefModel.svh"

  pipelineCpu #(.pcInit(pcInit)) pipelineCpu_inst (
    .CLK, .nRST, .ihit, .imemload, .imemREN, .imemaddr, .dhit, .dmemload,
    .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt
  );

  always #2 CLK = ~CLK;

  task automatic stopRun();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stopRun();
  endtask

  task automatic failRun(string msg);
    $display("%s", msg);
    stopRun();
  endtask

  task automatic checkStore(word_t addr, word_t data);
    if (storeIdx >= expAddr.size())
      failRun($sformatf("unexpected extra store of %h to %h", data, addr));
    else if (addr !== expAddr[storeIdx] || data !== expData[storeIdx])
      mismatch($sformatf("store %0d wrote %h to %h, expected %h to %h", storeIdx,
                         data, addr, expData[storeIdx], expAddr[storeIdx]));
    storeIdx++;
  endtask

  task automatic checkHalt(logic h, logic ren, logic wen);
    if (h !== 1'b1 || ren !== 1'b0 || wen !== 1'b0)
      mismatch($sformatf("after halt got halt=%b imemREN=%b dmemWEN=%b", h, ren, wen));
  endtask

  task automatic checkIdle(logic ren, word_t addr, logic dren, logic dwen, logic h);
    if (ren !== 1'b1 || addr !== pcInit || dren !== 1'b0 || dwen !== 1'b0 || h !== 1'b0)
      mismatch($sformatf("reset state imemREN=%b imemaddr=%h dmemREN=%b dmemWEN=%b halt=%b",
                         ren, addr, dren, dwen, h));
  endtask

  function automatic int pickWait();
    return randomMode ? int'($urandom_range(3, 0)) : 0;
  endfunction

  // memory models decide at mid cycle, where DUT outputs are settled
  always @(negedge CLK) begin
    if (!nRST) begin
      iNext = 0;
      dNext = 0;
    end else begin
      iNext = ihit ? pickWait() : iCnt - 1;
      if ((dmemREN || dmemWEN) && dhit) begin
        if (dmemWEN) begin
          checkStore(dmemaddr, dmemstore);
          dataMem[dmemaddr] = dmemstore;
        end
        dNext = pickWait();
      end else begin
        dNext = (dCnt > 0) ? dCnt - 1 : 0;
      end
    end
  end

  always @(posedge CLK) begin
    #1;
    iCnt = iNext;
    dCnt = dNext;
    ihit = (iCnt == 0);
    dhit = (dCnt == 0) && (dmemREN || dmemWEN);  // only a pending request gets a hit
    imemload = imem[8'((imemaddr - pcInit) >> 2)];
    dmemload = dataMem.exists(dmemaddr) ? dataMem[dmemaddr] : memFill(dmemaddr);
  end

  // timeout, limit set per run from the executed instruction count
  always @(posedge CLK) begin
    if (running) begin
      cycles++;
      if (cycles > cycleLimit)
        failRun($sformatf("run timed out after %0d cycles without halt", cycles));
    end
  end

  task automatic runProgram(bit randomWaits);
    refRun();
    for (int k = 0; k < 256; k++) imem[k] = (k < prog.size()) ? prog[k] : haltWord;
    dataMem.delete();
    storeIdx   = 0;
    cycles     = 0;
    cycleLimit = 16 * refCount + 200;
    @(posedge CLK);
    #1;
    randomMode = randomWaits;
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    checkIdle(imemREN, imemaddr, dmemREN, dmemWEN, halt);
    running = 1'b1;
    while (!halt) @(negedge CLK);
    running = 1'b0;
    repeat (20) begin
      @(negedge CLK);
      checkHalt(halt, imemREN, dmemWEN);
    end
    if (storeIdx != expAddr.size())
      failRun($sformatf("only %0d of %0d expected stores were seen", storeIdx,
                        expAddr.size()));
  endtask

  initial begin
    void'($urandom(42));
    CLK = 1'b0;
    nRST = 1'b0;
    ihit = 1'b1;
    dhit = 1'b1;
    imemload = haltWord;
    dmemload = '0;
    running = 1'b0;
    randomMode = 1'b0;
    iNext = 0;
    dNext = 0;

    buildRandomMix(24);
    runProgram(1'b0);
    runProgram(1'b1);

    // dependent chains and load-use
    prog = '{iOp(ADDIU, 5'd1, 5'd0, 16'd5), rOp(ADDU, 5'd2, 5'd1, 5'd1, 5'd0),
             rOp(SUBU, 5'd3, 5'd2, 5'd1, 5'd0), iOp(SW, 5'd3, 5'd0, 16'h200),
             iOp(LW, 5'd4, 5'd0, 16'h300), rOp(ADDU, 5'd5, 5'd4, 5'd3, 5'd0),
             iOp(SW, 5'd5, 5'd0, 16'h204), iOp(LW, 5'd6, 5'd0, 16'h200),
             rOp(SLL, 5'd7, 5'd0, 5'd6, 5'd4), iOp(SW, 5'd7, 5'd0, 16'h208),
             rOp(SLT, 5'd8, 5'd4, 5'd3, 5'd0), iOp(SW, 5'd8, 5'd0, 16'h20c), haltWord};
    runProgram(1'b0);
    runProgram(1'b1);

    // countdown loop, flushed shadows, one not-taken BEQ
    prog = '{iOp(ADDIU, 5'd1, 5'd0, 16'd3), iOp(ADDIU, 5'd3, 5'd0, 16'd9),
             iOp(SW, 5'd1, 5'd0, 16'h500), iOp(ADDIU, 5'd1, 5'd1, 16'hffff),
             iOp(BEQ, 5'd0, 5'd1, 16'd4), iOp(SW, 5'd1, 5'd0, 16'h504),
             iOp(BEQ, 5'd0, 5'd0, 16'hfffb), iOp(SW, 5'd3, 5'd0, 16'h5f0),
             iOp(SW, 5'd3, 5'd0, 16'h5f4), iOp(BEQ, 5'd3, 5'd1, 16'd1),
             iOp(SW, 5'd3, 5'd0, 16'h508), haltWord};
    runProgram(1'b0);
    runProgram(1'b1);

    $display("Test OK");
    $finish;
  end

endmodule

// File: project.f
+incdir+tb
source/cpuTypesPkg.sv
source/fetchStage.sv
source/registerFile.sv
source/decodeUnit.sv
source/executeUnit.sv
source/memWriteback.sv
source/pipelineCpu.sv
tb/tbPipelineCpu.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tbPipelineCpu -f project.f -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "Test OK"
